/* src/uartRegPkg.sv */
// UART register map
package uartRegPkg;

	// ------------------------------
	// register addresses
	localparam logic [1:0] RegTrb  = 2'd0;  // tx push on write, rx pop on read
	localparam logic [1:0] RegStat = 2'd1;
	localparam logic [1:0] RegCmd  = 2'd2;
	localparam logic [1:0] RegCtrl = 2'd3;

	// ------------------------------
	// command register bits
	localparam int CmdDtr       = 0;  // drives dtr active
	localparam int CmdRxIe      = 1;
	localparam int CmdTxIe      = 2;
	localparam int CmdRts       = 3;
	localparam int CmdLoop      = 4;  // local loopback
	localparam int CmdParityLsb = 5;  // 3-bit parity code up to bit 7

	// control register bits
	localparam int CtrlWordLen = 5;   // 2 bits, 0 is 8 data bits and 3 is 5
	localparam int CtrlStop2   = 7;
	localparam int CtrlRxClear = 17;  // self clearing
	localparam int CtrlTxClear = 18;  // self clearing
	localparam int CtrlBaudLsb = 16;  // 16-bit increment in the top half

	// ------------------------------
	// status register bits
	localparam int StParity    = 0;
	localparam int StFrame     = 1;
	localparam int StOverrun   = 2;
	localparam int StRxAvail   = 3;
	localparam int StTxNotFull = 4;
	localparam int StCts       = 5;
	localparam int StIrq       = 7;
	localparam int StRxLevel   = 8;   // lsb of the rx level field
	localparam int StTxLevel   = 12;  // lsb of the tx level field

	// values after reset
	localparam logic [31:0] CmdReset     = 32'h0000_0000;  // modem lines off, no parity
	localparam logic [15:0] CtrlReset    = 16'h0000;       // 8N1
	localparam logic [15:0] BaudIncReset = 16'd201;        // 19.2k baud from 100 MHz

endpackage

/* src/uartFramePkg.sv */
// Serial frame format
package uartFramePkg;

	// parity codes, bit 0 is the enable as on the 6551
	localparam logic [2:0] ParNone  = 3'd0;
	localparam logic [2:0] ParOdd   = 3'd1;
	localparam logic [2:0] ParEven  = 3'd3;
	localparam logic [2:0] ParMark  = 3'd5;   // forced 1
	localparam logic [2:0] ParSpace = 3'd7;   // forced 0

	// buffering
	localparam int FifoDepth     = 8;
	localparam int FifoLevelBits = 4;   // holds 0 up to FifoDepth

	// one received character with its error flags
	typedef struct packed {
		logic [7:0] data;
		logic       parityErr;
		logic       frameErr;
	} rxEntry;

	// parity bit for a code, given the xor of the data bits
	function automatic logic parityBit(input logic [2:0] code, input logic dataXor);
		case (code)
			ParOdd:   return ~dataXor;
			ParEven:  return dataXor;
			ParMark:  return 1'b1;
			ParSpace: return 1'b0;
			ParNone:  return 1'b1;   // idle level, never framed
			default:  return 1'b1;
		endcase
	endfunction

endpackage

/* src/serialFifo.sv */
// Synchronous FIFO
`timescale 1ns/100ps
module serialFifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     clear_i,      // synchronous flush
	input  logic     push_i,
	input  payload_t pushData_i,
	input  logic     pop_i,
	output payload_t headData_o,   // oldest entry
	output logic     empty_o,
	output logic     full_o,
	output logic [uartFramePkg::FifoLevelBits-1:0] level_o
);
	import uartFramePkg::*;

	payload_t mem [FifoDepth];
	logic [$clog2(FifoDepth)-1:0] rdPtr;
	logic [$clog2(FifoDepth)-1:0] wrPtr;
	logic [FifoLevelBits-1:0] count;
	logic doPush;
	logic doPop;

	assign doPush = push_i && !full_o;
	assign doPop  = pop_i && !empty_o;

	always_ff @(posedge clk_i) begin
		if (doPush)
			mem[wrPtr] <= pushData_i;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk_i) begin
		if (rst_i || clear_i) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + FifoLevelBits'(doPush) - FifoLevelBits'(doPop);
		end
	end

	assign headData_o = mem[rdPtr];
	assign empty_o    = (count == '0);
	assign full_o     = (count == FifoLevelBits'(FifoDepth));
	assign level_o    = count;

	// producers look at full themselves, the receiver drops and flags overrun
	pushWhenFull: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
	// the transmitter and the bus side only pop a present entry
	popWhenEmpty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

/* src/baudTickGen.sv */
// Baud tick generator
`timescale 1ns/100ps
module baudTickGen (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [15:0] baudInc_i,   // phase step per clock
	output logic        tick16_o     // one cycle per 16th of a bit
);
	logic [15:0] acc;
	logic [15:0] accNext;
	logic        carry;

	assign {carry, accNext} = {1'b0, acc} + {1'b0, baudInc_i};

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acc      <= '0;
			tick16_o <= 1'b0;
		end else begin
			acc      <= accNext;
			tick16_o <= carry;      // registered carry out
		end
	end

	// after a wrap the accumulator sits below the last step,
	// so two steps of at most half scale cannot wrap twice in a row
	tickSingle: assert property (@(posedge clk_i) disable iff (rst_i)
		(tick16_o && baudInc_i <= 16'h8000 && $past(baudInc_i) <= 16'h8000) |=> !tick16_o);

endmodule

/* src/uartTransmitter.sv */
// Serial transmitter
`timescale 1ns/100ps
module uartTransmitter (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       tick16_i,
	input  logic       ctsOk_i,       // synchronized clear to send
	input  logic [1:0] wordLen_i,
	input  logic [2:0] parity_i,
	input  logic       stop2_i,
	input  logic       fifoEmpty_i,
	input  logic [7:0] fifoData_i,
	output logic       pop_o,
	output logic       txd_o
);
	import uartFramePkg::*;

	typedef enum logic [2:0] {TxIdle, TxStart, TxData, TxParity, TxStop} txState_e;

	txState_e   state;
	logic [7:0] shiftReg;
	logic [3:0] tickCnt;      // 16 ticks per bit
	logic [2:0] bitCnt;
	logic       parAcc;       // xor of the bits sent so far
	logic       bitEnd;
	logic [2:0] lastBit;

	// cts only gates the start of a character
	assign pop_o   = (state == TxIdle) && !fifoEmpty_i && ctsOk_i;
	assign bitEnd  = tick16_i && (tickCnt == 4'd15);
	assign lastBit = 3'd7 - {1'b0, wordLen_i};

	always_comb begin
		case (state)
			TxStart:  txd_o = 1'b0;
			TxData:   txd_o = shiftReg[0];    // lsb first
			TxParity: txd_o = parityBit(parity_i, parAcc);
			default:  txd_o = 1'b1;           // idle and stop
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (pop_o)
			shiftReg <= fifoData_i;
		else if (state == TxData && bitEnd)
			shiftReg <= shiftReg >> 1;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state   <= TxIdle;
			tickCnt <= '0;
			bitCnt  <= '0;
			parAcc  <= 1'b0;
		end else begin
			if (tick16_i)
				tickCnt <= tickCnt + 4'd1;
			case (state)
				TxIdle: begin
					if (pop_o) begin
						state   <= TxStart;
						tickCnt <= '0;          // bit timing starts here
						bitCnt  <= '0;
						parAcc  <= 1'b0;
					end
				end
				TxStart: begin
					if (bitEnd)
						state <= TxData;
				end
				TxData: begin
					if (bitEnd) begin
						parAcc <= parAcc ^ shiftReg[0];
						if (bitCnt == lastBit) begin
							bitCnt <= '0;
							state  <= parity_i[0] ? TxParity : TxStop;
						end else begin
							bitCnt <= bitCnt + 3'd1;
						end
					end
				end
				TxParity: begin
					if (bitEnd)
						state <= TxStop;
				end
				default: begin    // stop bits
					if (bitEnd) begin
						if (stop2_i && !bitCnt[0])
							bitCnt <= 3'd1;
						else
							state <= TxIdle;
					end
				end
			endcase
		end
	end

endmodule

/* src/uartReceiver.sv */
// Serial receiver
`timescale 1ns/100ps
module uartReceiver (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       tick16_i,
	input  logic       rxd_i,        // asynchronous line
	input  logic [1:0] wordLen_i,
	input  logic [2:0] parity_i,
	input  logic       stop2_i,
	input  logic       fifoFull_i,
	output logic       push_o,
	output uartFramePkg::rxEntry entry_o,
	output logic       overrun_o     // character lost, fifo full
);
	import uartFramePkg::*;

	typedef enum logic [2:0] {
		RxIdle, RxStart, RxData, RxParity, RxStop, RxStop2
	} rxState_e;

	rxState_e   state;
	logic [1:0] rxSync;
	logic       rxBit;
	logic       rxPrev;       // for the falling edge
	logic [7:0] shiftReg;
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	logic       parAcc;
	logic       parErr;
	logic       sample;       // middle of a bit
	logic [2:0] lastBit;

	assign rxBit   = rxSync[1];
	assign sample  = tick16_i && (tickCnt == 4'd15);
	assign lastBit = 3'd7 - {1'b0, wordLen_i};

	// ------------------------------
	// data path, bits enter at the top
	always_ff @(posedge clk_i) begin
		if (state == RxData && sample)
			shiftReg <= {rxBit, shiftReg[7:1]};
		if (state == RxStop && sample) begin
			entry_o.data      <= shiftReg >> wordLen_i;   // short words end up high
			entry_o.parityErr <= parErr;
			entry_o.frameErr  <= !rxBit;                  // low stop bit
		end
	end

	// ------------------------------
	// control
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rxSync    <= 2'b11;     // line idles high
			rxPrev    <= 1'b1;
			state     <= RxIdle;
			tickCnt   <= '0;
			bitCnt    <= '0;
			parAcc    <= 1'b0;
			parErr    <= 1'b0;
			push_o    <= 1'b0;
			overrun_o <= 1'b0;
		end else begin
			rxSync    <= {rxSync[0], rxd_i};
			rxPrev    <= rxBit;
			push_o    <= 1'b0;
			overrun_o <= 1'b0;
			if (tick16_i)
				tickCnt <= tickCnt + 4'd1;
			case (state)
				RxIdle: begin
					if (rxPrev && !rxBit) begin
						state   <= RxStart;
						tickCnt <= '0;
					end
				end
				RxStart: begin
					// confirm at tick 8, which is mid start bit
					if (tick16_i && tickCnt == 4'd7) begin
						tickCnt <= '0;
						bitCnt  <= '0;
						parAcc  <= 1'b0;
						parErr  <= 1'b0;
						state   <= rxBit ? RxIdle : RxData;   // glitch goes back
					end
				end
				RxData: begin
					if (sample) begin
						parAcc <= parAcc ^ rxBit;
						if (bitCnt == lastBit)
							state <= parity_i[0] ? RxParity : RxStop;
						else
							bitCnt <= bitCnt + 3'd1;
					end
				end
				RxParity: begin
					if (sample) begin
						parErr <= (rxBit != parityBit(parity_i, parAcc));
						state  <= RxStop;
					end
				end
				RxStop: begin
					if (sample) begin
						push_o    <= !fifoFull_i;
						overrun_o <= fifoFull_i;
						state     <= (stop2_i && rxBit) ? RxStop2 : RxIdle;
					end
				end
				default: begin   // ride out the second stop bit
					if (sample)
						state <= RxIdle;
				end
			endcase
		end
	end

endmodule

/* src/uartRegFile.sv */
// UART bus registers
`timescale 1ns/100ps
module uartRegFile (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cs_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [1:0]  adr_i,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic        irq_o,
	input  logic        cts_ni,
	output logic        rts_no,
	output logic        dtr_no,
	output logic        txPush_o,
	output logic [7:0]  txData_o,
	input  logic        txFull_i,
	input  logic        txEmpty_i,
	input  logic [uartFramePkg::FifoLevelBits-1:0] txLevel_i,
	output logic        txClear_o,
	output logic        rxPop_o,
	input  uartFramePkg::rxEntry rxHead_i,
	input  logic        rxEmpty_i,
	input  logic [uartFramePkg::FifoLevelBits-1:0] rxLevel_i,
	output logic        rxClear_o,
	input  logic        overrun_i,
	output logic        ctsOk_o,
	output logic        loop_o,
	output logic [1:0]  wordLen_o,
	output logic [2:0]  parity_o,
	output logic        stop2_o,
	output logic [15:0] baudInc_o
);
	import uartRegPkg::*;
	import uartFramePkg::*;

	logic        cycle;
	logic        wrAck;
	logic        rdAck;
	logic        wrCtrl;
	logic [31:0] cmdReg;
	logic [15:0] ctrlReg;     // low half of CTRL
	logic [15:0] baudInc;     // high half of CTRL
	logic [1:0]  ctsSync;
	logic        overrunHold; // sticky until a status read
	logic [31:0] status;

	// ------------------------------
	// bus handshake
	assign cycle  = cs_i && cyc_i && stb_i;
	assign wrAck  = ack_o && we_i;
	assign rdAck  = ack_o && !we_i;
	assign wrCtrl = wrAck && adr_i == RegCtrl;

	// fifo strobes on the ack cycle
	assign txPush_o = wrAck && adr_i == RegTrb && sel_i[0] && !txFull_i;
	assign txData_o = dat_i[7:0];
	assign rxPop_o  = rdAck && adr_i == RegTrb && !rxEmpty_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o       <= 1'b0;
			cmdReg      <= CmdReset;
			ctrlReg     <= CtrlReset;
			baudInc     <= BaudIncReset;
			txClear_o   <= 1'b0;
			rxClear_o   <= 1'b0;
			ctsSync     <= 2'b00;
			overrunHold <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			ack_o <= cycle && !ack_o;   // one cycle, then wait for stb to drop
			if (wrAck && adr_i == RegCmd) begin
				for (int i = 0; i < 4; i++)
					if (sel_i[i])
						cmdReg[8*i +: 8] <= dat_i[8*i +: 8];
			end
			if (wrCtrl) begin
				if (sel_i[0])
					ctrlReg[7:0] <= dat_i[7:0];
				if (sel_i[1])
					ctrlReg[15:8] <= dat_i[15:8];
				if (sel_i[2])
					baudInc[7:0] <= dat_i[CtrlBaudLsb +: 8];
				if (sel_i[3])
					baudInc[15:8] <= dat_i[CtrlBaudLsb+8 +: 8];
			end
			// clear strobes share byte lane 2 with the baud increment
			rxClear_o <= wrCtrl && sel_i[2] && dat_i[CtrlRxClear];
			txClear_o <= wrCtrl && sel_i[2] && dat_i[CtrlTxClear];
			// cts from rts in loopback
			ctsSync <= {ctsSync[0], cmdReg[CmdLoop] ? cmdReg[CmdRts] : !cts_ni};
			if (overrun_i)
				overrunHold <= 1'b1;
			else if (rdAck && adr_i == RegStat)
				overrunHold <= 1'b0;
			irq_o <= (cmdReg[CmdRxIe] && !rxEmpty_i) || (cmdReg[CmdTxIe] && txEmpty_i);
		end
	end

	// ------------------------------
	// status and read mux
	always_comb begin
		status                             = '0;
		status[StParity]                   = !rxEmpty_i && rxHead_i.parityErr;
		status[StFrame]                    = !rxEmpty_i && rxHead_i.frameErr;
		status[StOverrun]                  = overrunHold;
		status[StRxAvail]                  = !rxEmpty_i;
		status[StTxNotFull]                = !txFull_i;
		status[StCts]                      = ctsOk_o;
		status[StIrq]                      = irq_o;
		status[StRxLevel +: FifoLevelBits] = rxLevel_i;
		status[StTxLevel +: FifoLevelBits] = txLevel_i;
	end

	always_comb begin
		case (adr_i)
			RegTrb:  dat_o = {22'h0, rxHead_i.frameErr, rxHead_i.parityErr, rxHead_i.data};
			RegStat: dat_o = status;
			RegCmd:  dat_o = cmdReg;
			RegCtrl: dat_o = {baudInc, ctrlReg};
		endcase
	end

	// modem lines are active low
	assign rts_no    = !cmdReg[CmdRts];
	assign dtr_no    = !cmdReg[CmdDtr];
	assign ctsOk_o   = ctsSync[1];
	assign loop_o    = cmdReg[CmdLoop];
	assign parity_o  = cmdReg[CmdParityLsb +: 3];
	assign wordLen_o = ctrlReg[CtrlWordLen +: 2];
	assign stop2_o   = ctrlReg[CtrlStop2];
	assign baudInc_o = baudInc;

	// the master holds its request through the ack cycle where writes and pops act
	ackHeld: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> cycle && $stable(adr_i) && $stable(we_i));

endmodule

/* src/uartTop.sv */
// UART top level
`timescale 1ns/100ps
module uartTop (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cs_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [1:0]  adr_i,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic        irq_o,
	input  logic        cts_ni,
	output logic        rts_no,
	output logic        dtr_no,
	input  logic        rxd_i,
	output logic        txd_o
);
	import uartFramePkg::*;

	logic tick16, ctsOk, loop, stop2;
	logic [1:0] wordLen;
	logic [2:0] parity;
	logic [15:0] baudInc;
	logic txPush, txFull, txEmpty, txClear, txPop, txdRaw;
	logic [7:0] txData, txHead;
	logic [FifoLevelBits-1:0] txLevel, rxLevel;
	logic rxPop, rxEmpty, rxFull, rxClear, rxPush, overrun, rxdMux;
	rxEntry rxHead, rxIn;

	// loopback turns the transmitter back into the receiver
	assign rxdMux = loop ? txdRaw : rxd_i;
	assign txd_o  = loop ? 1'b1 : txdRaw;    // line held idle

	uartRegFile regFile (
		.clk_i, .rst_i, .cs_i, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_i, .dat_o, .ack_o,
		.irq_o, .cts_ni, .rts_no, .dtr_no,
		.txPush_o(txPush), .txData_o(txData), .txFull_i(txFull), .txEmpty_i(txEmpty),
		.txLevel_i(txLevel), .txClear_o(txClear),
		.rxPop_o(rxPop), .rxHead_i(rxHead), .rxEmpty_i(rxEmpty), .rxLevel_i(rxLevel),
		.rxClear_o(rxClear), .overrun_i(overrun),
		.ctsOk_o(ctsOk), .loop_o(loop), .wordLen_o(wordLen), .parity_o(parity),
		.stop2_o(stop2), .baudInc_o(baudInc)
	);

	baudTickGen baudGen (.clk_i, .rst_i, .baudInc_i(baudInc), .tick16_o(tick16));

	serialFifo #(.payload_t(logic [7:0])) txFifo (
		.clk_i, .rst_i, .clear_i(txClear), .push_i(txPush), .pushData_i(txData),
		.pop_i(txPop), .headData_o(txHead), .empty_o(txEmpty), .full_o(txFull),
		.level_o(txLevel)
	);

	uartTransmitter transmitter (
		.clk_i, .rst_i, .tick16_i(tick16), .ctsOk_i(ctsOk), .wordLen_i(wordLen),
		.parity_i(parity), .stop2_i(stop2), .fifoEmpty_i(txEmpty), .fifoData_i(txHead),
		.pop_o(txPop), .txd_o(txdRaw)
	);

	uartReceiver receiver (
		.clk_i, .rst_i, .tick16_i(tick16), .rxd_i(rxdMux), .wordLen_i(wordLen),
		.parity_i(parity), .stop2_i(stop2), .fifoFull_i(rxFull), .push_o(rxPush),
		.entry_o(rxIn), .overrun_o(overrun)
	);

	serialFifo #(.payload_t(rxEntry)) rxFifo (
		.clk_i, .rst_i, .clear_i(rxClear), .push_i(rxPush), .pushData_i(rxIn),
		.pop_i(rxPop), .headData_o(rxHead), .empty_o(rxEmpty), .full_o(rxFull),
		.level_o(rxLevel)
	);

endmodule

/* testbench/uartTb.sv */
// UART testbench
`timescale 1ns/100ps
module uartTb;
	import uartRegPkg::*;
	import uartFramePkg::*;

	localparam int BitClks     = 32;            // 16 ticks, one tick every 2 clocks
	localparam int AckTimeout  = 16;
	localparam int PollTimeout = 400;
	localparam int LineTimeout = 6 * BitClks;   // no start bit after this
	localparam logic [15:0] TbBaud = 16'h8000;

	logic        clk;
	logic        rst;
	logic        cs;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [3:0]  sel;
	logic [1:0]  adr;
	logic [31:0] datIn;
	logic [31:0] datOut;
	logic        ack;
	logic        irq;
	logic        ctsN;
	logic        rtsN;
	logic        dtrN;
	logic        rxd;
	logic        txd;

	int          seed = 60230;
	int          errCount = 0;
	int          errAtStart = 0;
	int          passCount = 0;
	int          failCount = 0;
	bit          loopOn = 0;      // mirrors the loopback command bit
	logic [15:0] ctrlLow = 16'h0;
	logic [31:0] rdData;
	logic [7:0]  byteVal;
	logic [7:0]  capData;
	logic        capPar;
	bit          capOk;

	uartTop uartTop_inst (
		.clk_i(clk), .rst_i(rst), .cs_i(cs), .cyc_i(cyc), .stb_i(stb), .we_i(we),
		.sel_i(sel), .adr_i(adr), .dat_i(datIn), .dat_o(datOut), .ack_o(ack), .irq_o(irq),
		.cts_ni(ctsN), .rts_no(rtsN), .dtr_no(dtrN), .rxd_i(rxd), .txd_o(txd)
	);

	always #2 clk = !clk;   // 4 ns period

	// ------------------------------
	// protocol checks
	ackFromStrobe: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cs && cyc && stb))
	else begin
		errCount++;
		$display("ack_o rose without a bus strobe one cycle earlier");
	end

	loopLineIdle: assert property (@(posedge clk) disable iff (rst) loopOn |-> txd)
	else begin
		errCount++;
		$display("txd_o left idle while in loopback");
	end

	// ------------------------------
	// helpers
	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			errCount++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reportFailure(input string msg);
		errCount++;
		$display("%s", msg);
	endtask

	task automatic waitClocks(input int n);
		repeat (n) begin
			@(posedge clk);
			#0.5;              // keep the drive offset
		end
	endtask

	task automatic endTest(input string name);
		if (errCount == errAtStart) begin
			passCount++;
			$display("test %s: ok", name);
		end else begin
			failCount++;
			$display("test %s: failed with %0d errors", name, errCount - errAtStart);
		end
		errAtStart = errCount;
	endtask

	// parity bit from the code and the data bits actually framed
	function automatic logic expParity(input logic [2:0] code, input logic [7:0] data,
			input int nbits);
		logic ones;
		ones = ^(data & 8'((1 << nbits) - 1));
		if (code == ParOdd)
			return !ones;
		else if (code == ParEven)
			return ones;
		else if (code == ParMark)
			return 1'b1;
		else
			return 1'b0;
	endfunction

	// ------------------------------
	// bus master
	task automatic busCycle(input logic write, input logic [1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		cs    = 1'b1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = write;
		sel   = 4'hf;
		adr   = addr;
		datIn = wdata;
		rdata = '0;
		n     = 0;
		do begin
			@(posedge clk);
			#0.5;
			n++;
		end while (!ack && n < AckTimeout);
		if (ack)
			rdata = datOut;    // head entry before the pop
		else
			reportFailure($sformatf("no bus acknowledge from register %0d", addr));
		waitClocks(1);         // ack cycle, register side acts here
		cs  = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic busWrite(input logic [1:0] addr, input logic [31:0] wdata);
		logic [31:0] ignored;
		busCycle(1'b1, addr, wdata, ignored);
	endtask

	task automatic busRead(input logic [1:0] addr, output logic [31:0] rdata);
		busCycle(1'b0, addr, 32'h0, rdata);
	endtask

	task automatic setCmd(input logic [31:0] value);
		if (!value[CmdLoop])
			loopOn = 0;
		busWrite(RegCmd, value);
		loopOn = value[CmdLoop];
	endtask

	task automatic setCtrl(input logic [15:0] low);
		ctrlLow = low;
		busWrite(RegCtrl, {TbBaud, low});
	endtask

	// clear strobes sit in the baud field, so restore it right after
	task automatic clearFifos();
		busWrite(RegCtrl, {TbBaud, ctrlLow} | (32'd1 << CtrlRxClear) | (32'd1 << CtrlTxClear));
		busWrite(RegCtrl, {TbBaud, ctrlLow});
	endtask

	task automatic waitRxAvail();
		logic [31:0] st;
		int n;
		st = '0;
		n  = 0;
		while (!st[StRxAvail] && n < PollTimeout) begin
			busRead(RegStat, st);
			n++;
		end
		if (!st[StRxAvail])
			reportFailure("no received byte showed up in the status register");
	endtask

	task automatic waitIrq(input logic exp);
		int n;
		n = 0;
		while (irq !== exp && n < PollTimeout) begin
			waitClocks(1);
			n++;
		end
		checkValue("irq_o", 32'(irq), 32'(exp));
	endtask

	// ------------------------------
	// serial line
	task automatic holdLine(input logic v);
		rxd = v;
		waitClocks(BitClks);
	endtask

	task automatic sendSerial(input logic [7:0] data, input int nbits, input logic [2:0] code,
			input bit badPar, input bit lowStop, input int nstop);
		holdLine(1'b0);                                  // start bit
		for (int i = 0; i < nbits; i++)
			holdLine(data[i]);                            // lsb first
		if (code[0])
			holdLine(expParity(code, data, nbits) ^ badPar);
		holdLine(!lowStop);
		if (nstop == 2)
			holdLine(1'b1);
		holdLine(1'b1);                                  // idle gap
	endtask

	task automatic captureSerial(input int nbits, input logic [2:0] code, input int nstop,
			output logic [7:0] data, output logic par, output bit seen);
		int n;
		data = '0;
		par  = 1'b0;
		n    = 0;
		while (txd && n < LineTimeout) begin
			waitClocks(1);
			n++;
		end
		seen = !txd;
		if (!seen)
			return;
		waitClocks(BitClks / 2);                         // middle of the start bit
		checkValue("txd_o start bit", 32'(txd), 32'h0);
		for (int i = 0; i < nbits; i++) begin
			waitClocks(BitClks);
			data[i] = txd;
		end
		if (code[0]) begin
			waitClocks(BitClks);
			par = txd;
		end
		for (int s = 0; s < nstop; s++) begin
			waitClocks(BitClks);
			checkValue("txd_o stop bit", 32'(txd), 32'h1);
		end
	endtask

	task automatic loopByte(input int nbits);
		logic [7:0]  b;
		logic [31:0] got;
		b = 8'($random(seed));
		busWrite(RegTrb, {24'h0, b});
		waitRxAvail();
		busRead(RegTrb, got);
		checkValue("dat_o trb loopback", got, {24'h0, b & 8'((1 << nbits) - 1)});
	endtask

	// ------------------------------
	// test sequence
	initial begin
		clk   = 1'b0;
		rst   = 1'b1;
		cs    = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		sel   = 4'h0;
		adr   = 2'd0;
		datIn = 32'h0;
		ctsN  = 1'b1;   // cts off
		rxd   = 1'b1;
		repeat (5) @(posedge clk);
		#0.5;
		rst = 1'b0;

		// reset state and readback
		checkValue("txd_o", 32'(txd), 32'h1);
		checkValue("rts_no", 32'(rtsN), 32'h1);
		checkValue("dtr_no", 32'(dtrN), 32'h1);
		checkValue("irq_o", 32'(irq), 32'h0);
		busRead(RegStat, rdData);
		checkValue("status tx not full", 32'(rdData[StTxNotFull]), 32'h1);
		checkValue("status rx avail", 32'(rdData[StRxAvail]), 32'h0);
		setCmd(32'h5a00_00e9);
		busRead(RegCmd, rdData);
		checkValue("dat_o cmd", rdData, 32'h5a00_00e9);
		checkValue("rts_no", 32'(rtsN), 32'h0);
		checkValue("dtr_no", 32'(dtrN), 32'h0);
		setCtrl(16'h34a0);
		busRead(RegCtrl, rdData);
		checkValue("dat_o ctrl", rdData, {TbBaud, 16'h34a0});
		endTest("reset and register readback");

		// loopback 8N1 then 7E2
		setCmd((32'd1 << CmdLoop) | (32'd1 << CmdRts));
		setCtrl(16'h0);
		repeat (4) loopByte(8);
		setCmd((32'd1 << CmdLoop) | (32'd1 << CmdRts) | (32'(ParEven) << CmdParityLsb));
		setCtrl(16'((1 << CtrlWordLen) | (1 << CtrlStop2)));
		repeat (4) loopByte(7);
		endTest("loopback");

		// external transmit, 8O2
		ctsN = 1'b0;
		setCmd((32'd1 << CmdRts) | (32'd1 << CmdDtr) | (32'(ParOdd) << CmdParityLsb));
		setCtrl(16'(1 << CtrlStop2));
		byteVal = 8'($random(seed));
		busWrite(RegTrb, {24'h0, byteVal});
		captureSerial(8, ParOdd, 2, capData, capPar, capOk);
		if (!capOk)
			reportFailure("no start bit on txd_o with cts asserted");
		checkValue("txd_o data", 32'(capData), 32'(byteVal));
		checkValue("txd_o parity", 32'(capPar), 32'(expParity(ParOdd, byteVal, 8)));
		ctsN = 1'b1;
		waitClocks(BitClks);                 // stop bit ends, cts sync settles
		busWrite(RegTrb, 32'h55);
		captureSerial(8, ParOdd, 2, capData, capPar, capOk);
		if (capOk)
			reportFailure("start bit on txd_o while cts is deasserted");
		endTest("external transmit");

		// receive errors, 8E1
		clearFifos();
		setCmd((32'd1 << CmdRts) | (32'd1 << CmdDtr) | (32'(ParEven) << CmdParityLsb));
		setCtrl(16'h0);
		byteVal = 8'($random(seed));
		sendSerial(byteVal, 8, ParEven, 1'b1, 1'b0, 1);
		waitRxAvail();
		busRead(RegStat, rdData);
		checkValue("status parity", 32'(rdData[StParity]), 32'h1);
		checkValue("status frame", 32'(rdData[StFrame]), 32'h0);
		busRead(RegTrb, rdData);
		checkValue("dat_o trb parity error", rdData, 32'({2'b01, byteVal}));
		sendSerial(byteVal, 8, ParEven, 1'b0, 1'b1, 1);
		waitRxAvail();
		busRead(RegStat, rdData);
		checkValue("status parity", 32'(rdData[StParity]), 32'h0);
		checkValue("status frame", 32'(rdData[StFrame]), 32'h1);
		busRead(RegTrb, rdData);
		checkValue("dat_o trb frame error", rdData, 32'({2'b10, byteVal}));
		for (int i = 0; i <= FifoDepth; i++)
			sendSerial(8'($random(seed)), 8, ParEven, 1'b0, 1'b0, 1);
		busRead(RegStat, rdData);
		checkValue("status overrun", 32'(rdData[StOverrun]), 32'h1);
		checkValue("status rx level", 32'(rdData[StRxLevel +: FifoLevelBits]), FifoDepth);
		busRead(RegStat, rdData);
		checkValue("status overrun after read", 32'(rdData[StOverrun]), 32'h0);
		clearFifos();
		endTest("receive errors");

		// interrupts, cts still off
		setCmd((32'd1 << CmdRts) | (32'd1 << CmdDtr) | (32'd1 << CmdRxIe));
		waitIrq(1'b0);
		byteVal = 8'($random(seed));
		sendSerial(byteVal, 8, ParNone, 1'b0, 1'b0, 1);
		waitIrq(1'b1);
		busRead(RegTrb, rdData);
		checkValue("dat_o trb", rdData, {24'h0, byteVal});
		waitIrq(1'b0);
		setCmd((32'd1 << CmdRts) | (32'd1 << CmdDtr) | (32'd1 << CmdTxIe));
		waitIrq(1'b1);                        // tx fifo empty
		for (int i = 0; i < FifoDepth; i++)
			busWrite(RegTrb, 32'($random(seed)) & 32'hff);
		waitIrq(1'b0);
		busRead(RegStat, rdData);
		checkValue("status tx not full", 32'(rdData[StTxNotFull]), 32'h0);
		checkValue("status tx level", 32'(rdData[StTxLevel +: FifoLevelBits]), FifoDepth);
		clearFifos();
		waitIrq(1'b1);
		endTest("interrupts");

		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
		if (errCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
src/uartRegPkg.sv
src/uartFramePkg.sv
src/serialFifo.sv
src/baudTickGen.sv
src/uartTransmitter.sv
src/uartReceiver.sv
src/uartRegFile.sv
src/uartTop.sv
testbench/uartTb.sv

/* Makefile */
SIM := obj_dir/VuartTb

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module uartTb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
